// File: build.f
logic/cache_geom_pkg.sv
logic/cache_ctrl_pkg.sv
logic/tag_store.sv
logic/line_store.sv
logic/miss_controller.sv
logic/data_cache.sv
test/slow_mem_model.sv
test/data_cache_tb.sv

// File: logic/cache_ctrl_pkg.sv
// Miss controller state encoding and memory request constants for the data cache
package cache_ctrl_pkg;

    // --------------------
    // Miss handling states
    // --------------------

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,  // Serving hits and watching for a miss
        ST_EVICT = 2'd1,  // Dirty victim going out
        ST_FILL  = 2'd2   // Missing line coming in
    } miss_state_e;

    // Request lines toward memory are one hot or idle
    localparam int unsigned MEM_REQ_W  = 2;
    localparam int unsigned MEM_RD_BIT = 0;
    localparam int unsigned MEM_WR_BIT = 1;

    localparam logic [MEM_REQ_W-1:0] MEM_REQ_NONE = 2'b00;
    localparam logic [MEM_REQ_W-1:0] MEM_REQ_RD   = 2'b01;
    localparam logic [MEM_REQ_W-1:0] MEM_REQ_WR   = 2'b10;

endpackage

// File: logic/cache_geom_pkg.sv
// Address split and data types shared by the data cache stores, controller and top level
package cache_geom_pkg;

    // --------------------
    // Address split
    // --------------------

    localparam int unsigned ADDR_W    = 30;  // Word address from the processor
    localparam int unsigned OFFSET_W  = 2;   // Four words per line
    localparam int unsigned DEF_SET_W = 2;   // Four sets unless the top level overrides

    // --------------------
    // Data types
    // --------------------

    // One processor word
    typedef logic [31:0] word_t;

    // One full line as moved in every memory transfer
    typedef logic [$bits(word_t)*(2**OFFSET_W)-1:0] line_t;

    // Word address with the offset dropped, as driven on the memory bus
    typedef logic [ADDR_W-OFFSET_W-1:0] line_addr_t;

    // Way select
    typedef logic way_t;  // 0 picks way 0, 1 picks way 1

endpackage

// File: logic/data_cache.sv
// Top of the 2-way write-back data cache between a word-wide processor port and line-wide memory
`timescale 1ns/1ps

module data_cache #(
    parameter int SET_W = cache_geom_pkg::DEF_SET_W
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              i_proc_read,
    input  logic                              i_proc_write,
    input  logic [cache_geom_pkg::ADDR_W-1:0] i_proc_addr,   // Word address
    input  cache_geom_pkg::word_t             i_proc_wdata,
    output logic                              o_proc_stall,
    output cache_geom_pkg::word_t             o_proc_rdata,
    output logic                              o_mem_read,
    output logic                              o_mem_write,
    output cache_geom_pkg::line_addr_t        o_mem_addr,
    output cache_geom_pkg::line_t             o_mem_wdata,
    input  logic                              i_mem_ready,
    input  cache_geom_pkg::line_t             i_mem_rdata
);
    import cache_geom_pkg::*;

    localparam int unsigned TAG_W = ADDR_W - OFFSET_W - SET_W;

    logic [TAG_W-1:0]    tag;
    logic [SET_W-1:0]    set_idx;
    logic [OFFSET_W-1:0] word_sel;
    line_addr_t          miss_addr;
    logic                req;
    logic                hit;
    logic                write_hit;
    logic                fill;
    logic                victim_dirty;
    way_t                hit_way;
    way_t                victim_way;
    line_addr_t          victim_addr;
    line_t               victim_line;
    line_t               fill_line;
    word_t               line_rdata;

    // --------------------
    // Address split
    // --------------------
    assign word_sel  = i_proc_addr[OFFSET_W-1:0];
    assign set_idx   = i_proc_addr[OFFSET_W +: SET_W];
    assign tag       = i_proc_addr[ADDR_W-1 -: TAG_W];
    assign miss_addr = i_proc_addr[ADDR_W-1:OFFSET_W];

    assign req       = i_proc_read | i_proc_write;
    assign write_hit = i_proc_write & hit;

    assign o_proc_stall = ~hit;
    assign o_proc_rdata = (i_proc_read && hit) ? line_rdata : '0;

    tag_store #(.SET_W(SET_W)) tag_store0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_set_idx      (set_idx),
        .i_tag          (tag),
        .i_access       (req),
        .i_write_hit    (write_hit),
        .i_fill         (fill),
        .i_fill_way     (victim_way),
        .o_hit          (hit),
        .o_hit_way      (hit_way),
        .o_victim_way   (victim_way),
        .o_victim_dirty (victim_dirty),
        .o_victim_addr  (victim_addr)
    );

    line_store #(.SET_W(SET_W)) line_store0 (
        .clk           (clk),
        .i_set_idx     (set_idx),
        .i_word_sel    (word_sel),
        .i_hit_way     (hit_way),
        .i_write_hit   (write_hit),
        .i_wdata       (i_proc_wdata),
        .i_fill        (fill),
        .i_fill_way    (victim_way),     // LRU way stays fixed while the miss runs
        .i_fill_line   (fill_line),
        .o_rdata       (line_rdata),
        .o_victim_line (victim_line)
    );

    miss_controller miss_controller0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_req          (req),
        .i_hit          (hit),
        .i_victim_dirty (victim_dirty),
        .i_victim_addr  (victim_addr),
        .i_victim_line  (victim_line),
        .i_miss_addr    (miss_addr),
        .i_mem_ready    (i_mem_ready),
        .i_mem_rdata    (i_mem_rdata),
        .o_fill         (fill),
        .o_fill_line    (fill_line),
        .o_mem_read     (o_mem_read),
        .o_mem_write    (o_mem_write),
        .o_mem_addr     (o_mem_addr),
        .o_mem_wdata    (o_mem_wdata)
    );

endmodule

// File: logic/line_store.sv
// Line data of both cache ways, read by word on a hit and written by word or by whole line
`timescale 1ns/1ps

module line_store #(
    parameter int SET_W = cache_geom_pkg::DEF_SET_W
) (
    input  logic                                clk,
    input  logic [SET_W-1:0]                    i_set_idx,
    input  logic [cache_geom_pkg::OFFSET_W-1:0] i_word_sel,
    input  cache_geom_pkg::way_t                i_hit_way,
    input  logic                                i_write_hit,
    input  cache_geom_pkg::word_t               i_wdata,
    input  logic                                i_fill,
    input  cache_geom_pkg::way_t                i_fill_way,
    input  cache_geom_pkg::line_t               i_fill_line,
    output cache_geom_pkg::word_t               o_rdata,
    output cache_geom_pkg::line_t               o_victim_line
);
    import cache_geom_pkg::*;

    localparam int unsigned SETS   = 2**SET_W;
    localparam int unsigned WORD_W = $bits(word_t);

    line_t lines [2][SETS];

    // Word of the hitting way
    assign o_rdata = lines[i_hit_way][i_set_idx][i_word_sel*WORD_W +: WORD_W];

    // Line that a dirty eviction writes back
    assign o_victim_line = lines[i_fill_way][i_set_idx];

    always_ff @(posedge clk) begin
        if (i_fill) begin
            lines[i_fill_way][i_set_idx] <= i_fill_line;
        end else if (i_write_hit) begin
            lines[i_hit_way][i_set_idx][i_word_sel*WORD_W +: WORD_W] <= i_wdata;
        end
    end

endmodule

// File: logic/miss_controller.sv
// FSM that handles a cache miss by writing back a dirty victim and refilling from slow memory
`timescale 1ns/1ps

module miss_controller (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       i_req,            // Read or write present
    input  logic                       i_hit,
    input  logic                       i_victim_dirty,
    input  cache_geom_pkg::line_addr_t i_victim_addr,
    input  cache_geom_pkg::line_t      i_victim_line,
    input  cache_geom_pkg::line_addr_t i_miss_addr,
    input  logic                       i_mem_ready,
    input  cache_geom_pkg::line_t      i_mem_rdata,
    output logic                       o_fill,
    output cache_geom_pkg::line_t      o_fill_line,
    output logic                       o_mem_read,
    output logic                       o_mem_write,
    output cache_geom_pkg::line_addr_t o_mem_addr,
    output cache_geom_pkg::line_t      o_mem_wdata
);
    import cache_geom_pkg::*;
    import cache_ctrl_pkg::*;

    miss_state_e          state;
    miss_state_e          state_nxt;
    logic [MEM_REQ_W-1:0] mem_req;
    logic [MEM_REQ_W-1:0] mem_req_nxt;
    logic                 miss;
    logic                 start_evict;
    logic                 start_read;

    assign miss = i_req && !i_hit;

    // --------------------
    // Next state
    // --------------------

    always_comb begin
        state_nxt   = state;
        mem_req_nxt = mem_req;
        start_evict = 1'b0;
        start_read  = 1'b0;
        case (state)
            ST_IDLE: begin
                if (miss && i_victim_dirty) begin
                    state_nxt   = ST_EVICT;
                    mem_req_nxt = MEM_REQ_WR;
                    start_evict = 1'b1;
                end else if (miss) begin
                    state_nxt   = ST_FILL;
                    mem_req_nxt = MEM_REQ_RD;
                    start_read  = 1'b1;
                end
            end
            ST_EVICT: begin
                // Fetch the missing line as soon as the write-back ends
                if (i_mem_ready) begin
                    state_nxt   = ST_FILL;
                    mem_req_nxt = MEM_REQ_RD;
                    start_read  = 1'b1;
                end
            end
            ST_FILL: begin
                if (i_mem_ready) begin
                    state_nxt   = ST_IDLE;
                    mem_req_nxt = MEM_REQ_NONE;
                end
            end
            default: begin
                state_nxt   = ST_IDLE;
                mem_req_nxt = MEM_REQ_NONE;
            end
        endcase
    end

    // --------------------
    // Registers
    // --------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            mem_req <= MEM_REQ_NONE;
        end else begin
            state   <= state_nxt;
            mem_req <= mem_req_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (start_evict) begin
            o_mem_addr  <= i_victim_addr;
            o_mem_wdata <= i_victim_line;
        end else if (start_read) begin
            o_mem_addr <= i_miss_addr;
        end
    end

    assign o_mem_read  = mem_req[MEM_RD_BIT];
    assign o_mem_write = mem_req[MEM_WR_BIT];

    // Returned line goes into the victim way at the ready edge
    assign o_fill      = (state == ST_FILL) && i_mem_ready;
    assign o_fill_line = i_mem_rdata;

    a_no_read_write: assert property (@(posedge clk) disable iff (!rst_n)
        !(o_mem_read && o_mem_write))
        else $error("miss_controller: memory read and write raised together");

endmodule

// File: logic/tag_store.sv
// Tag, valid, dirty and LRU bookkeeping of the 2-way data cache with hit and victim lookup
`timescale 1ns/1ps

module tag_store #(
    parameter int SET_W = cache_geom_pkg::DEF_SET_W
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [SET_W-1:0]          i_set_idx,
    input  logic [cache_geom_pkg::ADDR_W-cache_geom_pkg::OFFSET_W-SET_W-1:0] i_tag,
    input  logic                      i_access,     // Read or write present
    input  logic                      i_write_hit,
    input  logic                      i_fill,
    input  cache_geom_pkg::way_t      i_fill_way,
    output logic                      o_hit,
    output cache_geom_pkg::way_t      o_hit_way,
    output cache_geom_pkg::way_t      o_victim_way,
    output logic                      o_victim_dirty,
    output cache_geom_pkg::line_addr_t o_victim_addr
);
    import cache_geom_pkg::*;

    localparam int unsigned TAG_W = ADDR_W - OFFSET_W - SET_W;
    localparam int unsigned SETS  = 2**SET_W;

    logic [1:0][SETS-1:0] valid;
    logic [1:0][SETS-1:0] dirty;
    logic [SETS-1:0]      lru;          // Way to replace next in each set
    logic [TAG_W-1:0]     tags [2][SETS];
    logic [1:0]           hit_vec;

    // --------------------
    // Lookup
    // --------------------

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            hit_vec[w] = valid[w][i_set_idx] && (tags[w][i_set_idx] == i_tag);
        end
    end

    assign o_hit     = |hit_vec;
    assign o_hit_way = hit_vec[1];

    assign o_victim_way   = lru[i_set_idx];
    assign o_victim_dirty = valid[o_victim_way][i_set_idx] & dirty[o_victim_way][i_set_idx];
    assign o_victim_addr  = {tags[o_victim_way][i_set_idx], i_set_idx};

    // --------------------
    // Update
    // --------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= '0;
            dirty <= '0;
            lru   <= '0;
        end else begin
            if (i_fill) begin
                valid[i_fill_way][i_set_idx] <= 1'b1;
                dirty[i_fill_way][i_set_idx] <= 1'b0;  // Refill lands clean
            end
            if (i_write_hit) begin
                dirty[o_hit_way][i_set_idx] <= 1'b1;
            end
            // Most recent user stays, the other way becomes the victim
            if (i_access && o_hit) begin
                lru[i_set_idx] <= ~o_hit_way;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_fill) begin
            tags[i_fill_way][i_set_idx] <= i_tag;
        end
    end

    // A line is never held in both ways of a set
    a_single_way_hit: assert property (@(posedge clk) disable iff (!rst_n)
        !(hit_vec[0] && hit_vec[1]))
        else $error("tag_store: both ways hit in set %0d", i_set_idx);

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the data cache testbench with Verilator, runs it and checks for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module data_cache_tb -o data_cache_sim

output=$(./obj_dir/data_cache_sim)
echo "$output"

if echo "$output" | grep -qx "Everything OK"; then
    exit 0
fi
exit 1

// File: test/data_cache_tb.sv
// Table-driven testbench for the data cache that checks read data and memory traffic
`timescale 1ns/1ps

module data_cache_tb;
    import cache_geom_pkg::*;

    localparam int          CLK_PERIOD     = 100;
    localparam int          MEM_LATENCY    = 3;
    localparam logic [31:0] INIT_PATTERN   = 32'hC0DE_5A00;
    localparam int          RAND_SEED      = 20;
    localparam int          NUM_ROWS       = 16;
    localparam int          TIMEOUT_CYCLES = 40 * NUM_ROWS + 100;

    logic              clk;
    logic              rst_n;
    logic              proc_read;
    logic              proc_write;
    logic [ADDR_W-1:0] proc_addr;
    word_t             proc_wdata;
    logic              proc_stall;
    word_t             proc_rdata;
    logic              mem_read;
    logic              mem_write;
    line_addr_t        mem_addr;
    line_t             mem_wdata;
    logic              mem_ready;
    line_t             mem_rdata;
    int unsigned       mem_reads;
    int unsigned       mem_writes;

    // --------------------
    // Stimulus table
    // --------------------
    string             row_name      [NUM_ROWS];
    logic              row_write     [NUM_ROWS];
    logic [ADDR_W-1:0] row_addr      [NUM_ROWS];
    word_t             row_wdata     [NUM_ROWS];
    word_t             row_exp_rdata [NUM_ROWS];
    int unsigned       row_reads     [NUM_ROWS];
    int unsigned       row_writes    [NUM_ROWS];
    int                n_rows;

    word_t shadow [logic [ADDR_W-1:0]];  // Words written so far
    int    errors;
    int    checks;
    int    cycle_count = 0;

    data_cache #(.SET_W(DEF_SET_W)) dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_proc_read  (proc_read),
        .i_proc_write (proc_write),
        .i_proc_addr  (proc_addr),
        .i_proc_wdata (proc_wdata),
        .o_proc_stall (proc_stall),
        .o_proc_rdata (proc_rdata),
        .o_mem_read   (mem_read),
        .o_mem_write  (mem_write),
        .o_mem_addr   (mem_addr),
        .o_mem_wdata  (mem_wdata),
        .i_mem_ready  (mem_ready),
        .i_mem_rdata  (mem_rdata)
    );

    slow_mem_model #(.LATENCY(MEM_LATENCY), .INIT_PATTERN(INIT_PATTERN)) mem0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_read        (mem_read),
        .i_write       (mem_write),
        .i_addr        (mem_addr),
        .i_wdata       (mem_wdata),
        .o_ready       (mem_ready),
        .o_rdata       (mem_rdata),
        .o_read_count  (mem_reads),
        .o_write_count (mem_writes)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the accesses did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    // Write data is random and read data comes from the shadow or the memory pattern
    task automatic add_row(input string name, input logic is_write,
                           input logic [ADDR_W-1:0] addr, input int unsigned reads,
                           input int unsigned writes);
        row_name[n_rows]   = name;
        row_write[n_rows]  = is_write;
        row_addr[n_rows]   = addr;
        row_reads[n_rows]  = reads;
        row_writes[n_rows] = writes;
        if (is_write) begin
            row_wdata[n_rows]     = $urandom;
            row_exp_rdata[n_rows] = '0;
            shadow[addr]          = row_wdata[n_rows];
        end else begin
            row_wdata[n_rows]     = '0;
            row_exp_rdata[n_rows] = shadow.exists(addr) ? shadow[addr]
                                                        : INIT_PATTERN ^ {2'b00, addr};
        end
        n_rows++;
    endtask

    task automatic build_table();
        add_row("rd_first",      1'b0, 30'h040, 1, 0);
        add_row("rd_same_line",  1'b0, 30'h041, 0, 0);
        add_row("wr_cached",     1'b1, 30'h042, 0, 0);
        add_row("rd_written",    1'b0, 30'h042, 0, 0);
        // Lines A B A C in set 1 so that C pushes out clean B
        add_row("lru_a",         1'b0, 30'h004, 1, 0);
        add_row("lru_b",         1'b0, 30'h015, 1, 0);
        add_row("lru_a_again",   1'b0, 30'h006, 0, 0);
        add_row("lru_c",         1'b0, 30'h027, 1, 0);
        add_row("lru_a_kept",    1'b0, 30'h005, 0, 0);
        // Dirty A in set 2 leaves when D comes in
        add_row("wb_write_a",    1'b1, 30'h108, 1, 0);
        add_row("wb_b",          1'b0, 30'h118, 1, 0);
        add_row("wb_d",          1'b0, 30'h128, 1, 1);
        add_row("wb_refill_a",   1'b0, 30'h108, 1, 0);
        add_row("wm_write",      1'b1, 30'h20C, 1, 0);
        add_row("wm_read",       1'b0, 30'h20C, 0, 0);
        add_row("wm_neighbor",   1'b0, 30'h20D, 0, 0);
    endtask

    task automatic apply_row(input int r);
        int unsigned reads_before;
        int unsigned writes_before;
        logic        stalled;
        word_t       rdata;
        @(negedge clk);
        reads_before  = mem_reads;
        writes_before = mem_writes;
        proc_read     = ~row_write[r];
        proc_write    = row_write[r];
        proc_addr     = row_addr[r];
        proc_wdata    = row_wdata[r];
        #(CLK_PERIOD/4);
        stalled = proc_stall;
        while (proc_stall) begin  // Hold the request through the miss
            @(negedge clk);
            #(CLK_PERIOD/4);
        end
        rdata  = proc_rdata;
        checks += 4;
        if (stalled !== (row_reads[r] != 0)) begin
            errors++;
            $display("Fail %s stall: expected %b, actual %b", row_name[r],
                     row_reads[r] != 0, stalled);
        end
        if (mem_reads - reads_before != row_reads[r]) begin
            errors++;
            $display("Fail %s memory reads: expected %0d, actual %0d", row_name[r],
                     row_reads[r], mem_reads - reads_before);
        end
        if (mem_writes - writes_before != row_writes[r]) begin
            errors++;
            $display("Fail %s memory writes: expected %0d, actual %0d", row_name[r],
                     row_writes[r], mem_writes - writes_before);
        end
        if (rdata !== row_exp_rdata[r]) begin
            errors++;
            $display("Fail %s read data: expected %h, actual %h", row_name[r],
                     row_exp_rdata[r], rdata);
        end
        @(posedge clk);  // Access completes here
    endtask

    initial begin
        int unsigned seed_sink;
        seed_sink  = $urandom(RAND_SEED);
        errors     = 0;
        checks     = 0;
        n_rows     = 0;
        rst_n      = 1'b0;
        proc_read  = 1'b0;
        proc_write = 1'b0;
        proc_addr  = '0;
        proc_wdata = '0;
        build_table();
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        #(CLK_PERIOD/4);
        checks++;
        if (mem_read !== 1'b0 || mem_write !== 1'b0) begin
            errors++;
            $display("Fail after_reset memory read/write: expected 0/0, actual %b/%b",
                     mem_read, mem_write);
        end
        for (int r = 0; r < n_rows; r++) begin
            apply_row(r);
        end
        @(negedge clk);
        proc_read  = 1'b0;
        proc_write = 1'b0;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: test/slow_mem_model.sv
// Line-wide slow memory that answers each data cache testbench request after a fixed latency
`timescale 1ns/1ps

module slow_mem_model #(
    parameter int          LATENCY      = 3,
    parameter logic [31:0] INIT_PATTERN = 32'h0
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       i_read,
    input  logic                       i_write,
    input  cache_geom_pkg::line_addr_t i_addr,
    input  cache_geom_pkg::line_t      i_wdata,
    output logic                       o_ready,
    output cache_geom_pkg::line_t      o_rdata,
    output int unsigned                o_read_count,
    output int unsigned                o_write_count
);
    import cache_geom_pkg::*;

    localparam int unsigned WORD_W = $bits(word_t);

    line_t       written [line_addr_t];  // Lines that came back from write-backs
    int unsigned wait_cnt;

    // Untouched memory holds the pattern xor the word address
    function automatic line_t pattern_line(input line_addr_t addr);
        line_t line;
        for (int i = 0; i < 4; i++) begin
            line[i*WORD_W +: WORD_W] = INIT_PATTERN ^ {2'b00, addr, i[OFFSET_W-1:0]};
        end
        return line;
    endfunction

    always @(posedge clk) begin
        if (!rst_n) begin
            o_ready       <= 1'b0;
            o_rdata       <= '0;
            wait_cnt      <= 0;
            o_read_count  <= 0;
            o_write_count <= 0;
        end else begin
            o_ready <= 1'b0;  // One-cycle pulse
            if ((i_read || i_write) && !o_ready) begin
                if (wait_cnt == LATENCY - 1) begin
                    wait_cnt <= 0;
                    o_ready  <= 1'b1;
                    if (i_write) begin
                        written[i_addr] = i_wdata;
                        o_write_count <= o_write_count + 1;
                    end else begin
                        o_rdata      <= written.exists(i_addr) ? written[i_addr]
                                                               : pattern_line(i_addr);
                        o_read_count <= o_read_count + 1;
                    end
                end else begin
                    wait_cnt <= wait_cnt + 1;
                end
            end
        end
    end

endmodule
